//--- Makefile
# Verilator build and run for the profiler subsystem testbench

TOP = xprof_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
	  -f compile.f --top-module $(TOP) -Mdir $(OBJ) -o V$(TOP)

# Pass only when the log holds the pass line
run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q -F '** PASS **' sim.log

clean:
	rm -rf $(OBJ) sim.log

//--- compile.f
+incdir+include
design/xprof_pkg.sv
design/xprof_apb_ctrl.sv
design/xcel_profiler.sv
design/xprof_readout.sv
design/xprof_top.sv
dv/xprof_props.sv
dv/xprof_tb.sv

//--- design/xcel_profiler.sv
/*
 * Profiler for one accelerator tile. Start clears and enables three
 * counters (kernel cycles, DRAM request cycles, DRAM response cycles);
 * stop freezes them until the next start.
 */
`timescale 1ns/10ps
`include "xprof_defines.svh"

module xcel_profiler (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  xprof_pkg::tile_cmd_t   cmd_i,
  input  xprof_pkg::xcel_mon_t   mon_i,
  output xprof_pkg::tile_stats_t stats_o
);

  xprof_pkg::prof_state_e state_q;
  xprof_pkg::prof_cnt_t   cyc_q;
  xprof_pkg::prof_cnt_t   req_q;
  xprof_pkg::prof_cnt_t   resp_q;

  // Strobes widened for the counter adders
  xprof_pkg::prof_cnt_t   req_inc;
  xprof_pkg::prof_cnt_t   resp_inc;

  assign req_inc  = xprof_pkg::prof_cnt_t'(mon_i.req_v);
  assign resp_inc = xprof_pkg::prof_cnt_t'(mon_i.resp_v);

  // ============================================================
  // State machine and counters
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= xprof_pkg::IDLE;
      cyc_q   <= '0;
      req_q   <= '0;
      resp_q  <= '0;
    end else begin
      case (state_q)
        xprof_pkg::IDLE,
        xprof_pkg::DONE: begin
          // Restart wipes the previous run
          if (cmd_i.start) begin
            state_q <= xprof_pkg::COUNT;
            cyc_q   <= '0;
            req_q   <= '0;
            resp_q  <= '0;
          end
        end

        xprof_pkg::COUNT: begin
          // The edge that applies stop still counts
          cyc_q  <= cyc_q + 1'b1;
          req_q  <= req_q + req_inc;
          resp_q <= resp_q + resp_inc;
          if (cmd_i.stop) begin
            state_q <= xprof_pkg::DONE;
          end
        end

        default: begin
          state_q <= xprof_pkg::IDLE;
        end
      endcase
    end
  end

  // ============================================================
  // Readable state
  // ============================================================
  always_comb begin
    stats_o.state  = state_q;
    stats_o.cycles = cyc_q;
    stats_o.reqs   = req_q;
    stats_o.resps  = resp_q;
  end

endmodule

//--- design/xprof_apb_ctrl.sv
/*
 * APB slave front end. Decodes the tile and register from paddr_i,
 * inserts one wait state per transfer, flags bad accesses, pulses
 * start/stop to the addressed tile and requests read data.
 */
`timescale 1ns/10ps
`include "xprof_defines.svh"

module xprof_apb_ctrl (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic [`XPROF_ADDR_W-1:0]                    paddr_i,
  input  logic                                        psel_i,
  input  logic                                        penable_i,
  input  logic                                        pwrite_i,
  input  logic [`XPROF_DATA_W-1:0]                    pwdata_i,
  output logic                                        pready_o,
  output logic                                        pslverr_o,
  output xprof_pkg::tile_cmd_t [`XPROF_NUM_TILES-1:0] cmd_o,
  output xprof_pkg::rd_sel_t                          rd_sel_o
);

  // Only the CTRL register accepts writes
  localparam xprof_pkg::reg_sel_t SEL_CTRL =
    xprof_pkg::reg_sel_t'(`XPROF_OFS_CTRL >> 2);

  // ============================================================
  // Address decode
  // ============================================================
  xprof_pkg::tile_idx_t tile;
  xprof_pkg::reg_sel_t  regsel;
  logic                 tile_ok;
  logic                 first_acc;
  logic                 bad_acc;
  logic                 wr_ok;

  // Wait-state flag, high during the completing cycle
  logic wait_q;
  logic err_q;

  xprof_pkg::tile_cmd_t [`XPROF_NUM_TILES-1:0] cmd_d;
  xprof_pkg::tile_cmd_t [`XPROF_NUM_TILES-1:0] cmd_q;

  // First access cycle of a transfer
  assign first_acc = psel_i & penable_i & ~wait_q;

  assign tile   = paddr_i[4 +: $bits(xprof_pkg::tile_idx_t)];
  assign regsel = paddr_i[3:2];

  // Bits above the window must also select an existing tile
  assign tile_ok = int'(paddr_i[`XPROF_ADDR_W-1:4]) < `XPROF_NUM_TILES;

  assign bad_acc = ~tile_ok | (pwrite_i & (regsel != SEL_CTRL));
  assign wr_ok   = first_acc & pwrite_i & ~bad_acc;

  // ============================================================
  // Command generation
  // ============================================================
  // Bit 0 of the write data picks start or stop
  always_comb begin
    for (int t = 0; t < `XPROF_NUM_TILES; t++) begin
      cmd_d[t].start = wr_ok & (tile == xprof_pkg::tile_idx_t'(t)) & pwdata_i[0];
      cmd_d[t].stop  = wr_ok & (tile == xprof_pkg::tile_idx_t'(t)) & ~pwdata_i[0];
    end
  end

  // Decision taken in the first access cycle, visible one cycle later
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wait_q <= 1'b0;
      err_q  <= 1'b0;
      cmd_q  <= '0;
    end else begin
      wait_q <= first_acc;
      err_q  <= first_acc & bad_acc;
      cmd_q  <= cmd_d;
    end
  end

  // ============================================================
  // Outputs
  // ============================================================
  assign pready_o  = wait_q;
  assign pslverr_o = err_q;
  assign cmd_o     = cmd_q;

  // Readout registers the selection at the same edge as wait_q
  always_comb begin
    rd_sel_o.valid  = first_acc & ~pwrite_i & tile_ok;
    rd_sel_o.tile   = tile;
    rd_sel_o.regsel = regsel;
  end

endmodule

//--- design/xprof_pkg.sv
/*
 * Shared types for the profiler subsystem: counter and index vectors,
 * the profiler state encoding and the structs passed between blocks.
 * Referenced by scoped name from every design file.
 */
`include "xprof_defines.svh"

package xprof_pkg;

  // ============================================================
  // Plain vectors
  // ============================================================
  // One counter value
  typedef logic [`XPROF_CNT_W-1:0] prof_cnt_t;

  // Tile index, taken from address bits 7:4
  typedef logic [3:0] tile_idx_t;

  // Register selector, address bits 3:2
  typedef logic [1:0] reg_sel_t;

  // ============================================================
  // Profiler state machine
  // ============================================================
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    COUNT = 2'd1,
    DONE  = 2'd2
  } prof_state_e;

  // ============================================================
  // Structs
  // ============================================================
  // DRAM activity strobes from one accelerator tile
  typedef struct packed {
    logic req_v;
    logic resp_v;
  } xcel_mon_t;

  // Single-cycle command to one profiler
  typedef struct packed {
    logic start;
    logic stop;
  } tile_cmd_t;

  // Everything the host can read back from one tile
  typedef struct packed {
    prof_state_e state;
    prof_cnt_t   cycles;
    prof_cnt_t   reqs;
    prof_cnt_t   resps;
  } tile_stats_t;

  // Read request from the APB decoder to the readout mux
  typedef struct packed {
    logic      valid;
    tile_idx_t tile;
    reg_sel_t  regsel;
  } rd_sel_t;

endpackage

//--- design/xprof_readout.sv
/*
 * Read data path. Picks one tile's state or counter according to the
 * decoder's selection and registers it onto prdata_o one cycle later.
 */
`timescale 1ns/10ps
`include "xprof_defines.svh"

module xprof_readout (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  xprof_pkg::rd_sel_t                            rd_sel_i,
  input  xprof_pkg::tile_stats_t [`XPROF_NUM_TILES-1:0] stats_i,
  output logic [`XPROF_DATA_W-1:0]                      prdata_o
);

  localparam xprof_pkg::reg_sel_t SEL_CTRL = xprof_pkg::reg_sel_t'(`XPROF_OFS_CTRL >> 2);
  localparam xprof_pkg::reg_sel_t SEL_CYC  = xprof_pkg::reg_sel_t'(`XPROF_OFS_CYC >> 2);
  localparam xprof_pkg::reg_sel_t SEL_REQ  = xprof_pkg::reg_sel_t'(`XPROF_OFS_REQ >> 2);
  localparam xprof_pkg::reg_sel_t SEL_RESP = xprof_pkg::reg_sel_t'(`XPROF_OFS_RESP >> 2);

  xprof_pkg::tile_stats_t     sel_stats;
  logic [`XPROF_DATA_W-1:0]   rd_data;

  // Tile mux, out-of-range indices never arrive with valid set
  always_comb begin
    sel_stats = '0;
    for (int t = 0; t < `XPROF_NUM_TILES; t++) begin
      if (rd_sel_i.tile == xprof_pkg::tile_idx_t'(t)) begin
        sel_stats = stats_i[t];
      end
    end
  end

  // Register mux
  always_comb begin
    case (rd_sel_i.regsel)
      SEL_CTRL: rd_data = {{(`XPROF_DATA_W-2){1'b0}}, sel_stats.state};
      SEL_CYC:  rd_data = sel_stats.cycles;
      SEL_REQ:  rd_data = sel_stats.reqs;
      SEL_RESP: rd_data = sel_stats.resps;
      default:  rd_data = '0;
    endcase
  end

  // Holds the last value between reads
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prdata_o <= '0;
    end else if (rd_sel_i.valid) begin
      prdata_o <= rd_data;
    end
  end

endmodule

//--- design/xprof_top.sv
/*
 * Profiler subsystem top. One APB slave port controls and reads back
 * a row of identical per-tile profilers fed by the tiles' DRAM strobes.
 */
`timescale 1ns/10ps
`include "xprof_defines.svh"

module xprof_top (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  // APB slave
  input  logic [`XPROF_ADDR_W-1:0]                    paddr_i,
  input  logic                                        psel_i,
  input  logic                                        penable_i,
  input  logic                                        pwrite_i,
  input  logic [`XPROF_DATA_W-1:0]                    pwdata_i,
  output logic [`XPROF_DATA_W-1:0]                    prdata_o,
  output logic                                        pready_o,
  output logic                                        pslverr_o,
  // Activity strobes, one entry per tile
  input  xprof_pkg::xcel_mon_t [`XPROF_NUM_TILES-1:0] mon_i
);

  xprof_pkg::tile_cmd_t   [`XPROF_NUM_TILES-1:0] tile_cmd;
  xprof_pkg::tile_stats_t [`XPROF_NUM_TILES-1:0] tile_stats;
  xprof_pkg::rd_sel_t                            rd_sel;

  // ============================================================
  // APB decode
  // ============================================================
  xprof_apb_ctrl u_ctrl (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cmd_o     (tile_cmd),
    .rd_sel_o  (rd_sel)
  );

  // ============================================================
  // Per-tile profilers
  // ============================================================
  for (genvar t = 0; t < `XPROF_NUM_TILES; t++) begin : g_tile
    xcel_profiler u_prof (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .cmd_i   (tile_cmd[t]),
      .mon_i   (mon_i[t]),
      .stats_o (tile_stats[t])
    );
  end

  // Read data
  xprof_readout u_readout (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .rd_sel_i (rd_sel),
    .stats_i  (tile_stats),
    .prdata_o (prdata_o)
  );

endmodule

//--- dv/xprof_props.sv
/*
 * Assertions for the profiler subsystem, bound into the top level.
 * Watches the APB wait state, the tile command pulses and the frozen
 * counters of a stopped profiler.
 */
`timescale 1ns/10ps
`include "xprof_defines.svh"

module xprof_props (
  input logic                                          clk_i,
  input logic                                          reset_i,
  input logic                                          psel_i,
  input logic                                          penable_i,
  input logic                                          pready_i,
  input logic                                          pslverr_i,
  input xprof_pkg::tile_cmd_t   [`XPROF_NUM_TILES-1:0] tile_cmd_i,
  input xprof_pkg::tile_stats_t [`XPROF_NUM_TILES-1:0] tile_stats_i
);

  // Number of failed assertions so far
  int unsigned fail_cnt = 0;

  // ============================================================
  // APB
  // ============================================================
  // First access cycle directly follows a setup cycle with penable low
  a_wait_state: assert property (@(posedge clk_i) disable iff (reset_i)
    (psel_i && penable_i && !$past(penable_i)) |-> !pready_i)
    else begin
      fail_cnt++;
      $error("pready_o high in the first access cycle");
    end

  a_err_with_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    pslverr_i |-> pready_i)
    else begin
      fail_cnt++;
      $error("pslverr_o high without pready_o");
    end

  // ============================================================
  // Per-tile commands and counters
  // ============================================================
  for (genvar t = 0; t < `XPROF_NUM_TILES; t++) begin : g_tile
    a_cmd_excl: assert property (@(posedge clk_i) disable iff (reset_i)
      !(tile_cmd_i[t].start && tile_cmd_i[t].stop))
      else begin
        fail_cnt++;
        $error("tile %0d got start and stop together", t);
      end

    // Commands last one cycle
    a_cmd_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
      (tile_cmd_i[t].start || tile_cmd_i[t].stop)
        |=> !(tile_cmd_i[t].start || tile_cmd_i[t].stop))
      else begin
        fail_cnt++;
        $error("tile %0d command longer than one cycle", t);
      end

    a_done_frozen: assert property (@(posedge clk_i) disable iff (reset_i)
      (tile_stats_i[t].state == xprof_pkg::DONE && !tile_cmd_i[t].start)
        |=> $stable(tile_stats_i[t].cycles))
      else begin
        fail_cnt++;
        $error("tile %0d cycle counter moved while stopped", t);
      end
  end

endmodule

bind xprof_top xprof_props u_props (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .psel_i       (psel_i),
  .penable_i    (penable_i),
  .pready_i     (pready_o),
  .pslverr_i    (pslverr_o),
  .tile_cmd_i   (tile_cmd),
  .tile_stats_i (tile_stats)
);

//--- dv/xprof_tb.sv
/*
 * Directed testbench for the profiler subsystem. Drives the APB port
 * and random DRAM strobes, keeps a counter model per tile and checks
 * every readback against it.
 */
`timescale 1ns/10ps
`include "xprof_defines.svh"

module xprof_tb;

  localparam int NT = `XPROF_NUM_TILES;

  // Rough length of reset plus the five tests, doubled for the limit
  localparam int TEST_CYCLES    = 18 + 64 + 74 + 140 + 135 + 90;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                          clk_i;
  logic                          reset_i;
  logic [`XPROF_ADDR_W-1:0]      paddr_i;
  logic                          psel_i;
  logic                          penable_i;
  logic                          pwrite_i;
  logic [`XPROF_DATA_W-1:0]      pwdata_i;
  logic [`XPROF_DATA_W-1:0]      prdata_o;
  logic                          pready_o;
  logic                          pslverr_o;
  xprof_pkg::xcel_mon_t [NT-1:0] mon_i;

  logic [31:0] lcg_state = 32'hbc44;
  int          cycle_cnt = 0;

  // Reference model with one entry per tile
  xprof_pkg::prof_state_e m_state [NT];
  logic [31:0]            m_cyc   [NT];
  logic [31:0]            m_req   [NT];
  logic [31:0]            m_resp  [NT];
  logic                   m_start [NT];
  logic                   m_stop  [NT];

  xprof_top DUT (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .mon_i     (mon_i)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // ============================================================
  // Stimulus, model and run limit
  // ============================================================
  function automatic logic [31:0] lcg_next(input logic [31:0] cur);
    lcg_next = cur * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper LCG bits feed the DRAM strobes of all tiles
  always @(posedge clk_i) begin
    if (reset_i) begin
      mon_i <= '0;
    end else begin
      lcg_state = lcg_next(lcg_state);
      mon_i <= lcg_state[31 -: 2*NT];
    end
  end

  // Every edge after the start edge counts up to and including the stop edge
  always @(posedge clk_i) begin
    for (int t = 0; t < NT; t++) begin
      if (reset_i) begin
        m_state[t] = xprof_pkg::IDLE;
        m_cyc[t]   = '0;
        m_req[t]   = '0;
        m_resp[t]  = '0;
        m_start[t] = 1'b0;
        m_stop[t]  = 1'b0;
      end else begin
        if (m_state[t] == xprof_pkg::COUNT) begin
          m_cyc[t]  = m_cyc[t] + 32'd1;
          m_req[t]  = m_req[t] + {31'b0, mon_i[t].req_v};
          m_resp[t] = m_resp[t] + {31'b0, mon_i[t].resp_v};
          if (m_stop[t]) begin
            m_state[t] = xprof_pkg::DONE;
          end
        end else if (m_start[t]) begin
          m_state[t] = xprof_pkg::COUNT;
          m_cyc[t]   = '0;
          m_req[t]   = '0;
          m_resp[t]  = '0;
        end
        m_start[t] = 1'b0;
        m_stop[t]  = 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (DUT.u_props.fail_cnt != 0) begin
      $display("A bound assertion failed at %0t", $time);
      fail_and_stop();
    end else if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      fail_and_stop();
    end
  end

  // ============================================================
  // Checking and APB helpers
  // ============================================================
  task automatic fail_and_stop();
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error @ %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      fail_and_stop();
    end
  endtask

  function automatic logic [`XPROF_ADDR_W-1:0] tile_addr(input int tile, input logic [3:0] ofs);
    tile_addr = {tile[`XPROF_ADDR_W-5:0], ofs};
  endfunction

  // Error for a bad tile or a write anywhere but CTRL
  function automatic logic expect_err(input logic wr, input logic [`XPROF_ADDR_W-1:0] addr);
    logic bad_tile;
    bad_tile   = int'(addr[`XPROF_ADDR_W-1:4]) >= NT;
    expect_err = bad_tile || (wr && (addr[3:0] != `XPROF_OFS_CTRL));
  endfunction

  task automatic apb_xfer(input logic wr, input logic [`XPROF_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    logic exp_err;
    int   tile;
    exp_err = expect_err(wr, addr);
    tile    = int'(addr[`XPROF_ADDR_W-1:4]);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    check_eq("pready_o in first access cycle", {31'b0, pready_o}, 32'd0);
    // Exactly one wait state, so the second access cycle completes
    @(negedge clk_i);
    check_eq("pready_o in second access cycle", {31'b0, pready_o}, 32'd1);
    check_eq("pslverr_o", {31'b0, pslverr_o}, {31'b0, exp_err});
    rdata = prdata_o;
    // Command lands at the completion edge
    if (wr && !exp_err) begin
      if (wdata[0]) begin
        m_start[tile] = 1'b1;
      end else begin
        m_stop[tile] = 1'b1;
      end
    end
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  task automatic apb_write(input logic [`XPROF_ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input logic [`XPROF_ADDR_W-1:0] addr, output logic [31:0] data);
    apb_xfer(1'b0, addr, '0, data);
  endtask

  task automatic start_tile(input int t);
    apb_write(tile_addr(t, `XPROF_OFS_CTRL), 32'd1);
  endtask

  task automatic stop_tile(input int t);
    apb_write(tile_addr(t, `XPROF_OFS_CTRL), 32'd0);
  endtask

  // Only valid while the tile is not counting
  task automatic check_tile(input int t);
    logic [31:0] rd;
    apb_read(tile_addr(t, `XPROF_OFS_CTRL), rd);
    check_eq($sformatf("tile %0d CTRL", t), rd, {30'b0, m_state[t]});
    apb_read(tile_addr(t, `XPROF_OFS_CYC), rd);
    check_eq($sformatf("tile %0d CYC", t), rd, m_cyc[t]);
    apb_read(tile_addr(t, `XPROF_OFS_REQ), rd);
    check_eq($sformatf("tile %0d REQ", t), rd, m_req[t]);
    apb_read(tile_addr(t, `XPROF_OFS_RESP), rd);
    check_eq($sformatf("tile %0d RESP", t), rd, m_resp[t]);
  endtask

  // ============================================================
  // Directed tests
  // ============================================================
  task automatic test_reset_state();
    for (int t = 0; t < NT; t++) begin
      check_tile(t);
    end
  endtask

  task automatic test_single_tile();
    logic [31:0] rd;
    start_tile(0);
    repeat (50) @(posedge clk_i);
    stop_tile(0);
    check_tile(0);
    apb_read(tile_addr(0, `XPROF_OFS_CTRL), rd);
    check_eq("tile 0 state after stop", rd, {30'b0, xprof_pkg::DONE});
  endtask

  task automatic test_overlap();
    logic [31:0] rd;
    start_tile(1);
    repeat (20) @(posedge clk_i);
    start_tile(3);
    repeat (30) @(posedge clk_i);
    stop_tile(1);
    repeat (15) @(posedge clk_i);
    stop_tile(3);
    check_tile(1);
    check_tile(2);
    check_tile(3);
    apb_read(tile_addr(2, `XPROF_OFS_CYC), rd);
    check_eq("idle tile 2 CYC", rd, 32'd0);
  endtask

  task automatic test_ignored_cmds();
    logic [31:0] rd;
    logic [31:0] long_cyc;
    // Stop in IDLE
    stop_tile(2);
    check_tile(2);
    // Second start lands while counting
    start_tile(0);
    repeat (20) @(posedge clk_i);
    start_tile(0);
    repeat (20) @(posedge clk_i);
    stop_tile(0);
    check_tile(0);
    apb_read(tile_addr(0, `XPROF_OFS_CYC), long_cyc);
    // Restart from DONE with a short run
    start_tile(0);
    repeat (5) @(posedge clk_i);
    stop_tile(0);
    check_tile(0);
    apb_read(tile_addr(0, `XPROF_OFS_CYC), rd);
    check_eq("restart clears tile 0 CYC", {31'b0, rd < long_cyc}, 32'd1);
  endtask

  task automatic test_errors();
    logic [31:0] rd;
    apb_write(tile_addr(1, `XPROF_OFS_CYC), 32'd1);
    apb_write(tile_addr(3, `XPROF_OFS_RESP), 32'd1);
    apb_write(tile_addr(NT, `XPROF_OFS_CTRL), 32'd1);
    // Tile 16 shares its low index bits with tile 0
    apb_write(tile_addr(16, `XPROF_OFS_CTRL), 32'd1);
    apb_read(tile_addr(NT, `XPROF_OFS_CYC), rd);
    apb_read(tile_addr(255, `XPROF_OFS_CTRL), rd);
    for (int t = 0; t < NT; t++) begin
      check_tile(t);
    end
  endtask

  initial begin
    reset_i   = 1'b1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    mon_i     = '0;
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;

    test_reset_state();
    test_single_tile();
    test_overlap();
    test_ignored_cmds();
    test_errors();

    if (DUT.u_props.fail_cnt != 0) begin
      $display("%0d bound assertion failures during the run", DUT.u_props.fail_cnt);
      fail_and_stop();
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

//--- include/xprof_defines.svh
/*
 * Build-time constants for the accelerator profiler subsystem.
 * Include wherever tile count, widths or register offsets are needed.
 */
`ifndef XPROF_DEFINES_SVH
`define XPROF_DEFINES_SVH

// ============================================================
// Sizing
// ============================================================
// Number of profiled tiles, 1 to 16
`define XPROF_NUM_TILES 4
`define XPROF_CNT_W     32
`define XPROF_ADDR_W    12
`define XPROF_DATA_W    32

// ============================================================
// Register map, byte offsets inside a 16-byte tile window
// ============================================================
`define XPROF_OFS_CTRL  4'h0
`define XPROF_OFS_CYC   4'h4
`define XPROF_OFS_REQ   4'h8
`define XPROF_OFS_RESP  4'hC

`endif
